//--- rtl/rv_isa_pkg.sv
// RISC-V base encoding constants and the instruction word union with its format views
package rv_isa_pkg;

    localparam int XLEN       = 64;
    localparam int INSN_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;

    // Major opcodes, bits 6:0
    localparam logic [OPCODE_W-1:0] OP_REG    = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OP_JALR   = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OP_AUIPC  = 7'b0010111;
    localparam logic [OPCODE_W-1:0] OP_SYSTEM = 7'b1110011;
    localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_REG_W  = 7'b0111011;
    localparam logic [OPCODE_W-1:0] OP_IMM_W  = 7'b0011011;

    localparam logic [FUNCT7_W-1:0] F7_BASE   = 7'h00;
    localparam logic [FUNCT7_W-1:0] F7_ALT    = 7'h20; // SUB and arithmetic shifts
    localparam logic [FUNCT7_W-1:0] F7_MULDIV = 7'h01; // M extension

    typedef struct packed {
        logic [FUNCT7_W-1:0]   funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [FUNCT3_W-1:0]   funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [OPCODE_W-1:0]   opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [FUNCT3_W-1:0]   funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [OPCODE_W-1:0]   opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [FUNCT3_W-1:0]   funct3;
        logic [4:0]            imm_4_0;
        logic [OPCODE_W-1:0]   opcode;
    } s_fmt_t;

    // Branch offset is scattered across the word
    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [FUNCT3_W-1:0]   funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [OPCODE_W-1:0]   opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [OPCODE_W-1:0]   opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [OPCODE_W-1:0]   opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } insn_word_u;

endpackage

//--- rtl/decode_pkg.sv
// Decoded instruction type codes, immediate format selector and decoder widths
package decode_pkg;

    localparam int TYPE_W      = 8;
    localparam int SHAMT_W     = 6;
    localparam int SHAMT_SEL_W = 2;

    typedef logic [TYPE_W-1:0] insn_type_t;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_t;

    // Width of the shift amount field carried between stages
    localparam logic [SHAMT_SEL_W-1:0] SHAMT_NONE = 2'd0;
    localparam logic [SHAMT_SEL_W-1:0] SHAMT_5    = 2'd1; // Word shifts
    localparam logic [SHAMT_SEL_W-1:0] SHAMT_6    = 2'd2; // RV64 shifts

    // R and M group
    localparam insn_type_t
        T_ADD    = 8'd0,  T_SUB    = 8'd1,  T_XOR    = 8'd2,  T_OR     = 8'd3,
        T_AND    = 8'd4,  T_SLL    = 8'd5,  T_SRL    = 8'd6,  T_SRA    = 8'd7,
        T_SLT    = 8'd8,  T_SLTU   = 8'd9,  T_MUL    = 8'd10, T_MULH   = 8'd11,
        T_MULHSU = 8'd12, T_MULHU  = 8'd13, T_DIV    = 8'd14, T_DIVU   = 8'd15,
        T_REM    = 8'd16, T_REMU   = 8'd17;

    // Immediate arithmetic, codes 27 and 28 unused
    localparam insn_type_t
        T_ADDI   = 8'd18, T_XORI   = 8'd19, T_ORI    = 8'd20, T_ANDI   = 8'd21,
        T_SLLI   = 8'd22, T_SRLI   = 8'd23, T_SRAI   = 8'd24, T_SLTI   = 8'd25,
        T_SLTIU  = 8'd26, T_ADDIW  = 8'd29, T_SLLIW  = 8'd30, T_SRLIW  = 8'd31,
        T_SRAIW  = 8'd32;

    // 32-bit word operations
    localparam insn_type_t
        T_ADDW   = 8'd33, T_SUBW   = 8'd34, T_SLLW   = 8'd35, T_SRLW   = 8'd36,
        T_SRAW   = 8'd37, T_MULW   = 8'd38, T_DIVW   = 8'd39, T_DIVUW  = 8'd40,
        T_REMW   = 8'd41, T_REMUW  = 8'd42;

    // Stores, branches, jumps, upper immediates, system, loads
    localparam insn_type_t
        T_SB     = 8'd43, T_SH     = 8'd44, T_SW     = 8'd45, T_SD     = 8'd46,
        T_BEQ    = 8'd47, T_BNE    = 8'd48, T_BLT    = 8'd49, T_BGE    = 8'd50,
        T_BLTU   = 8'd51, T_BGEU   = 8'd52, T_JAL    = 8'd53, T_JALR   = 8'd54,
        T_LUI    = 8'd55, T_AUIPC  = 8'd56, T_ECALL  = 8'd57, T_EBREAK = 8'd58,
        T_LB     = 8'd59, T_LH     = 8'd60, T_LW     = 8'd61, T_LBU    = 8'd62,
        T_LHU    = 8'd63, T_LWU    = 8'd64, T_LD     = 8'd65;

    localparam insn_type_t T_UNKNOWN = 8'd255;

endpackage

//--- rtl/insn_classifier.sv
// Decode stage one: instruction type, immediate format, shift width and memory flag
`timescale 1ns/1ps

module insn_classifier
    import rv_isa_pkg::*, decode_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [INSN_W-1:0]      instruction,
    input  logic                   decode_enable,
    output logic                   stage1_valid,
    output logic [INSN_W-1:0]      stage1_word,
    output insn_type_t             stage1_type,
    output imm_fmt_t               stage1_imm_fmt,
    output logic [SHAMT_SEL_W-1:0] stage1_shamt_w,
    output logic                   stage1_mem
);

    insn_word_u             word;
    logic [FUNCT3_W-1:0]    funct3;
    logic [FUNCT7_W-1:0]    funct7;
    logic                   accept;
    insn_type_t             type_d;
    imm_fmt_t               fmt_d;
    logic [SHAMT_SEL_W-1:0] shamt_w_d;
    logic                   mem_d;

    assign word   = instruction;
    assign funct3 = word.r_fmt.funct3;
    assign funct7 = word.r_fmt.funct7;
    assign accept = decode_enable && (instruction != '0); // Zero word is ignored

    always_comb begin
        type_d = T_UNKNOWN;
        fmt_d  = IMM_NONE;
        case (word.r_fmt.opcode)
            OP_REG: begin
                case (funct7)
                    F7_BASE: begin
                        case (funct3)
                            3'b000: type_d = T_ADD;
                            3'b001: type_d = T_SLL;
                            3'b010: type_d = T_SLT;
                            3'b011: type_d = T_SLTU;
                            3'b100: type_d = T_XOR;
                            3'b101: type_d = T_SRL;
                            3'b110: type_d = T_OR;
                            3'b111: type_d = T_AND;
                        endcase
                    end
                    F7_ALT: begin
                        if (funct3 == 3'b000) type_d = T_SUB;
                        else if (funct3 == 3'b101) type_d = T_SRA;
                    end
                    F7_MULDIV: begin
                        case (funct3)
                            3'b000: type_d = T_MUL;
                            3'b001: type_d = T_MULH;
                            3'b010: type_d = T_MULHSU;
                            3'b011: type_d = T_MULHU;
                            3'b100: type_d = T_DIV;
                            3'b101: type_d = T_DIVU;
                            3'b110: type_d = T_REM;
                            3'b111: type_d = T_REMU;
                        endcase
                    end
                    default: type_d = T_UNKNOWN;
                endcase
            end
            OP_IMM: begin
                fmt_d = IMM_I;
                case (funct3)
                    3'b000: type_d = T_ADDI;
                    3'b010: type_d = T_SLTI;
                    3'b011: type_d = T_SLTIU;
                    3'b100: type_d = T_XORI;
                    3'b110: type_d = T_ORI;
                    3'b111: type_d = T_ANDI;
                    3'b001: if (word.i_fmt.imm[11:6] == F7_BASE[6:1]) type_d = T_SLLI;
                    3'b101: begin
                        // Bit 25 belongs to shamt, so only 31:26 select the shift
                        if (word.i_fmt.imm[11:6] == F7_BASE[6:1]) type_d = T_SRLI;
                        else if (word.i_fmt.imm[11:6] == F7_ALT[6:1]) type_d = T_SRAI;
                    end
                endcase
            end
            OP_IMM_W: begin
                fmt_d = IMM_I;
                case (funct3)
                    3'b000: type_d = T_ADDIW;
                    3'b001: if (funct7 == F7_BASE) type_d = T_SLLIW;
                    3'b101: begin
                        if (funct7 == F7_BASE) type_d = T_SRLIW;
                        else if (funct7 == F7_ALT) type_d = T_SRAIW;
                    end
                    default: type_d = T_UNKNOWN;
                endcase
            end
            OP_REG_W: begin
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}:   type_d = T_ADDW;
                    {F7_BASE, 3'b001}:   type_d = T_SLLW;
                    {F7_BASE, 3'b101}:   type_d = T_SRLW;
                    {F7_ALT, 3'b000}:    type_d = T_SUBW;
                    {F7_ALT, 3'b101}:    type_d = T_SRAW;
                    {F7_MULDIV, 3'b000}: type_d = T_MULW;
                    {F7_MULDIV, 3'b100}: type_d = T_DIVW;
                    {F7_MULDIV, 3'b101}: type_d = T_DIVUW;
                    {F7_MULDIV, 3'b110}: type_d = T_REMW;
                    {F7_MULDIV, 3'b111}: type_d = T_REMUW;
                    default:             type_d = T_UNKNOWN;
                endcase
            end
            OP_STORE: begin
                fmt_d = IMM_S;
                case (funct3)
                    3'b000:  type_d = T_SB;
                    3'b001:  type_d = T_SH;
                    3'b010:  type_d = T_SW;
                    3'b011:  type_d = T_SD;
                    default: type_d = T_UNKNOWN;
                endcase
            end
            OP_BRANCH: begin
                fmt_d = IMM_B;
                case (funct3)
                    3'b000:  type_d = T_BEQ;
                    3'b001:  type_d = T_BNE;
                    3'b100:  type_d = T_BLT;
                    3'b101:  type_d = T_BGE;
                    3'b110:  type_d = T_BLTU;
                    3'b111:  type_d = T_BGEU;
                    default: type_d = T_UNKNOWN;
                endcase
            end
            OP_LOAD: begin
                fmt_d = IMM_I; // Load offset
                case (funct3)
                    3'b000:  type_d = T_LB;
                    3'b001:  type_d = T_LH;
                    3'b010:  type_d = T_LW;
                    3'b011:  type_d = T_LD;
                    3'b100:  type_d = T_LBU;
                    3'b101:  type_d = T_LHU;
                    3'b110:  type_d = T_LWU;
                    default: type_d = T_UNKNOWN;
                endcase
            end
            OP_SYSTEM: begin
                fmt_d = IMM_I;
                if (funct3 == 3'b000 && word.i_fmt.imm == 12'h000) type_d = T_ECALL;
                else if (funct3 == 3'b000 && word.i_fmt.imm == 12'h001) type_d = T_EBREAK;
            end
            OP_JAL: begin
                fmt_d  = IMM_J;
                type_d = T_JAL;
            end
            OP_JALR: begin
                fmt_d  = IMM_I;
                type_d = T_JALR;
            end
            OP_LUI: begin
                fmt_d  = IMM_U;
                type_d = T_LUI;
            end
            OP_AUIPC: begin
                fmt_d  = IMM_U;
                type_d = T_AUIPC;
            end
            default: type_d = T_UNKNOWN;
        endcase
    end

    // Shift amount only for recognised immediate shifts
    assign shamt_w_d = (type_d inside {T_SLLI, T_SRLI, T_SRAI})    ? SHAMT_6 :
                       (type_d inside {T_SLLIW, T_SRLIW, T_SRAIW}) ? SHAMT_5 : SHAMT_NONE;
    assign mem_d     = (word.r_fmt.opcode == OP_LOAD) || (word.r_fmt.opcode == OP_STORE);

    always_ff @(posedge clk) begin
        if (rst) begin
            stage1_valid <= 1'b0;
        end else begin
            stage1_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage1_word    <= instruction;
            stage1_type    <= type_d;
            stage1_imm_fmt <= fmt_d;
            stage1_shamt_w <= shamt_w_d;
            stage1_mem     <= mem_d;
        end
    end

endmodule

//--- rtl/operand_extractor.sv
// Decode stage two: register fields, zero-extended immediate, shift amount and outputs
`timescale 1ns/1ps

module operand_extractor
    import rv_isa_pkg::*, decode_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stage1_valid,
    input  logic [INSN_W-1:0]      stage1_word,
    input  insn_type_t             stage1_type,
    input  imm_fmt_t               stage1_imm_fmt,
    input  logic [SHAMT_SEL_W-1:0] stage1_shamt_w,
    input  logic                   stage1_mem,
    output logic [OPCODE_W-1:0]    opcode,
    output logic [REG_ADDR_W-1:0]  rd,
    output logic [REG_ADDR_W-1:0]  rs1,
    output logic [REG_ADDR_W-1:0]  rs2,
    output logic [XLEN-1:0]        imm,
    output logic [XLEN-1:0]        shamt,
    output insn_type_t             instruction_type,
    output logic                   memory_access,
    output logic                   decode_complete
);

    insn_word_u         word;
    logic [XLEN-1:0]    imm_d;
    logic [SHAMT_W-1:0] shamt_d;

    assign word = stage1_word;

    // Fields packed and zero-extended, sign bit 31 is not replicated
    always_comb begin
        case (stage1_imm_fmt)
            IMM_I: imm_d = XLEN'(word.i_fmt.imm);
            IMM_S: imm_d = XLEN'({word.s_fmt.imm_11_5, word.s_fmt.imm_4_0});
            IMM_B: begin
                imm_d = XLEN'({word.b_fmt.imm_11, word.b_fmt.imm_10_5,
                               word.b_fmt.imm_4_1, 1'b0});
            end
            IMM_U: imm_d = XLEN'(word.u_fmt.imm_31_12); // Right-aligned
            IMM_J: begin
                imm_d = XLEN'({word.j_fmt.imm_19_12, word.j_fmt.imm_11,
                               word.j_fmt.imm_10_1, 1'b0});
            end
            default: imm_d = '0;
        endcase
    end

    always_comb begin
        case (stage1_shamt_w)
            SHAMT_6: shamt_d = word.i_fmt.imm[5:0];         // Bits 25:20
            SHAMT_5: shamt_d = {1'b0, word.i_fmt.imm[4:0]}; // Bits 24:20
            default: shamt_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decode_complete  <= 1'b0;
            memory_access    <= 1'b0;
            opcode           <= '0;
            rd               <= '0;
            rs1              <= '0;
            rs2              <= '0;
            imm              <= '0;
            shamt            <= '0;
            instruction_type <= '0;
        end else begin
            decode_complete <= stage1_valid;
            if (stage1_valid) begin // Outputs hold between results
                memory_access    <= stage1_mem;
                opcode           <= word.r_fmt.opcode;
                rd               <= word.r_fmt.rd;
                rs1              <= word.r_fmt.rs1;
                rs2              <= word.r_fmt.rs2;
                imm              <= imm_d;
                shamt            <= XLEN'(shamt_d);
                instruction_type <= stage1_type;
            end
        end
    end

endmodule

//--- rtl/insn_decoder.sv
// Two-stage RV64IM decoder top level joining classifier and operand extractor
`timescale 1ns/1ps

module insn_decoder
    import rv_isa_pkg::*, decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [INSN_W-1:0]     instruction,
    input  logic                  decode_enable,
    output logic [OPCODE_W-1:0]   opcode,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [XLEN-1:0]       imm,
    output logic [XLEN-1:0]       shamt,
    output insn_type_t            instruction_type,
    output logic                  memory_access,
    output logic                  decode_complete
);

    // Stage one results
    logic                   stage1_valid;
    logic [INSN_W-1:0]      stage1_word;
    insn_type_t             stage1_type;
    imm_fmt_t               stage1_imm_fmt;
    logic [SHAMT_SEL_W-1:0] stage1_shamt_w;
    logic                   stage1_mem;

    insn_classifier i_classifier (
        .clk            (clk),
        .rst            (rst),
        .instruction    (instruction),
        .decode_enable  (decode_enable),
        .stage1_valid   (stage1_valid),
        .stage1_word    (stage1_word),
        .stage1_type    (stage1_type),
        .stage1_imm_fmt (stage1_imm_fmt),
        .stage1_shamt_w (stage1_shamt_w),
        .stage1_mem     (stage1_mem)
    );

    operand_extractor i_extractor (
        .clk              (clk),
        .rst              (rst),
        .stage1_valid     (stage1_valid),
        .stage1_word      (stage1_word),
        .stage1_type      (stage1_type),
        .stage1_imm_fmt   (stage1_imm_fmt),
        .stage1_shamt_w   (stage1_shamt_w),
        .stage1_mem       (stage1_mem),
        .opcode           (opcode),
        .rd               (rd),
        .rs1              (rs1),
        .rs2              (rs2),
        .imm              (imm),
        .shamt            (shamt),
        .instruction_type (instruction_type),
        .memory_access    (memory_access),
        .decode_complete  (decode_complete)
    );

endmodule

//--- sim/tb_insn_decoder.sv
// Testbench for the two-stage decoder, stimulus file reader, result checker and watchdog
`timescale 1ns/1ps

module tb_insn_decoder
    import rv_isa_pkg::*, decode_pkg::*;
();

    localparam int          CLK_PERIOD = 100;
    localparam int          MAX_TESTS  = 64;
    localparam int          NAME_W     = 8 * 24;
    localparam logic [31:0] LFSR_SEED  = 32'd93213;
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003; // x^32 + x^22 + x^2 + x + 1

    typedef struct packed {
        logic [NAME_W-1:0] name;
        logic [INSN_W-1:0] word;
        logic [TYPE_W-1:0] itype;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   shamt;
        logic              mem;
        logic              quiet; // No decode_complete may follow
        logic [31:0]       due;
    } expect_t;

    logic                  clk;
    logic                  rst;
    logic [INSN_W-1:0]     instruction;
    logic                  decode_enable;
    logic [OPCODE_W-1:0]   opcode;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       shamt;
    insn_type_t            instruction_type;
    logic                  memory_access;
    logic                  decode_complete;

    // Test table from the stimulus file
    logic [NAME_W-1:0] t_name  [MAX_TESTS];
    logic [INSN_W-1:0] t_word  [MAX_TESTS];
    logic              t_en    [MAX_TESTS];
    logic [TYPE_W-1:0] t_type  [MAX_TESTS];
    logic [XLEN-1:0]   t_imm   [MAX_TESTS];
    logic [XLEN-1:0]   t_shamt [MAX_TESTS];
    logic              t_mem   [MAX_TESTS];

    expect_t     exp_q[$];
    int          num_tests    = 0;
    int          cycle        = 0; // Rising edges so far
    int          errors       = 0;
    int          test_errors  = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [31:0] lfsr;
    logic        loaded       = 1'b0;

    insn_decoder i_insn_decoder (
        .clk              (clk),
        .rst              (rst),
        .instruction      (instruction),
        .decode_enable    (decode_enable),
        .opcode           (opcode),
        .rd               (rd),
        .rs1              (rs1),
        .rs2              (rs2),
        .imm              (imm),
        .shamt            (shamt),
        .instruction_type (instruction_type),
        .memory_access    (memory_access),
        .decode_complete  (decode_complete)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) next = next ^ LFSR_TAPS; // Galois feedback
        return next;
    endfunction

    task automatic abort_run(input string reason);
        $display("%0s", reason);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic compare_field(input logic [NAME_W-1:0] name, input string field,
                                 input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %0s: %0s expected 0x%0h, actual 0x%0h",
                     name, field, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input logic [NAME_W-1:0] name);
        if (test_errors == 0) begin
            $display("Test %0s passed", name);
            tests_passed++;
        end else begin
            $display("Test %0s failed with %0d errors", name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic load_stimulus();
        int                fd;
        int                code;
        logic [NAME_W-1:0] tok;
        logic [8*160-1:0]  rest;
        fd = $fopen("sim/decode_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/decode_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                tok  = '0;
                code = $fscanf(fd, "%s", tok);
                if (code != 1) break;
                if (tok == "#") begin
                    code = $fgets(rest, fd); // Skip comment text
                end else begin
                    code = $fscanf(fd, "%h %d %d %h %h %d", t_word[num_tests],
                                   t_en[num_tests], t_type[num_tests], t_imm[num_tests],
                                   t_shamt[num_tests], t_mem[num_tests]);
                    if (code != 6) begin
                        $display("A line of the stimulus file could not be parsed");
                        errors++;
                        break;
                    end
                    t_name[num_tests] = tok;
                    num_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Runs once per falling edge while outputs are stable
    task automatic check_outputs();
        expect_t e;
        if (exp_q.size() > 0 && exp_q[0].quiet && exp_q[0].due == cycle) begin
            e           = exp_q.pop_front();
            test_errors = 0;
            if (decode_complete) begin
                $display("Test %0s: decode_complete pulsed for a word that must be ignored",
                         e.name);
                errors++;
                test_errors++;
            end
            report_test(e.name);
        end else if (decode_complete) begin
            if (exp_q.size() == 0 || exp_q[0].quiet) begin
                $display("decode_complete went high at cycle %0d with no word outstanding",
                         cycle);
                errors++;
            end else begin
                e           = exp_q.pop_front();
                test_errors = 0;
                compare_field(e.name, "latency", e.due, cycle);
                compare_field(e.name, "type", e.itype, instruction_type);
                compare_field(e.name, "imm", e.imm, imm);
                compare_field(e.name, "shamt", e.shamt, shamt);
                compare_field(e.name, "memory_access", e.mem, memory_access);
                compare_field(e.name, "opcode", e.word[6:0], opcode);
                compare_field(e.name, "rd", e.word[11:7], rd);
                compare_field(e.name, "rs1", e.word[19:15], rs1);
                compare_field(e.name, "rs2", e.word[24:20], rs2);
                report_test(e.name);
            end
        end else if (exp_q.size() > 0 && exp_q[0].due <= cycle) begin
            e = exp_q.pop_front();
            $display("Test %0s: decode_complete never arrived for this word", e.name);
            errors++;
            tests_failed++;
        end
    endtask

    initial begin
        expect_t e;
        logic    gap;
        rst           = 1'b1;
        instruction   = '0;
        decode_enable = 1'b0;
        lfsr          = LFSR_SEED;
        load_stimulus();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        test_errors = 0;
        compare_field("reset", "decode_complete", 1'b0, decode_complete);
        compare_field("reset", "memory_access", 1'b0, memory_access);
        compare_field("reset", "imm", '0, imm);
        compare_field("reset", "shamt", '0, shamt);
        compare_field("reset", "type", '0, instruction_type);
        report_test("reset");
        rst = 1'b0;

        for (int i = 0; i < num_tests; i++) begin
            @(negedge clk);
            check_outputs();
            gap  = lfsr[0];
            lfsr = lfsr_step(lfsr);
            if (gap) begin
                instruction   = '0;
                decode_enable = 1'b0;
                @(negedge clk);
                check_outputs();
            end
            instruction   = t_word[i];
            decode_enable = t_en[i];
            e.name  = t_name[i];
            e.word  = t_word[i];
            e.itype = t_type[i];
            e.imm   = t_imm[i];
            e.shamt = t_shamt[i];
            e.mem   = t_mem[i];
            e.quiet = !(t_en[i] && t_word[i] != '0);
            e.due   = cycle + 2; // Accepted at the next edge and completed one edge later
            exp_q.push_back(e);
        end

        @(negedge clk);
        check_outputs();
        instruction   = '0;
        decode_enable = 1'b0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            check_outputs();
        end
        repeat (2) begin // Catch stray pulses
            @(negedge clk);
            check_outputs();
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Two cycles per word at most plus reset and drain
    initial begin
        wait (loaded);
        #((num_tests * 2 + 20) * CLK_PERIOD);
        abort_run("Timeout: the decoder did not finish all words in the allowed time");
    end

endmodule

//--- sim/decode_stimulus.txt
# Columns: test name, instruction word (hex), decode_enable, expected type (decimal),
# expected immediate (hex), expected shamt (hex), expected memory_access
add          003100B3 1 0   0     0  0
sub          407302B3 1 1   0     0  0
sra          40C5D533 1 7   0     0  0
sltu         005231B3 1 9   0     0  0
mul          023100B3 1 10  0     0  0
divu         023150B3 1 15  0     0  0
remu         02A4F433 1 17  0     0  0
addw         003100BB 1 33  0     0  0
subw         403100BB 1 34  0     0  0
sraw         403150BB 1 37  0     0  0
remuw        023170BB 1 42  0     0  0
r_bad_funct  403110B3 1 255 0     0  0
rw_bad_funct 023110BB 1 255 0     0  0
addi_neg     FFF10093 1 18  FFF   0  0
andi         7A537293 1 21  7A5   0  0
slli_63      03F11093 1 22  3F    3F 0
srli_33      02115093 1 23  21    21 0
srai_40      42815093 1 24  428   28 0
srli_bad     04515093 1 255 45    0  0
addiw        1001009B 1 29  100   0  0
slliw_31     01F1109B 1 30  1F    1F 0
sraiw_20     4141509B 1 32  414   14 0
iw_bad_funct 0001209B 1 255 0     0  0
ld           01033283 1 65  10    0  1
lbu          7FF44383 1 62  7FF   0  1
load_bad     00017083 1 255 0     0  1
sd           2A323423 1 46  2A8   0  1
sb_neg       FE110FA3 1 43  FFF   0  1
store_bad    00004023 1 255 0     0  1
beq          00208863 1 47  10    0  0
bgeu_bits    D43275E3 1 52  D4A   0  0
branch_bad   00002063 1 255 0     0  0
jal          AABA50EF 1 53  A5AAA 0  0
jalr         123100E7 1 54  123   0  0
lui          ABCDE2B7 1 55  ABCDE 0  0
auipc        12345097 1 56  12345 0  0
ecall        00000073 1 57  0     0  0
ebreak       00100073 1 58  1     0  0
csrrw_bad    300110F3 1 255 300   0  0
fence_bad    0000000F 1 255 0     0  0
zero_word    00000000 1 0   0     0  0
disabled_add 003100B3 0 0   0     0  0

//--- vlog.f
rtl/rv_isa_pkg.sv
rtl/decode_pkg.sv
rtl/insn_classifier.sv
rtl/operand_extractor.sv
rtl/insn_decoder.sv
sim/tb_insn_decoder.sv

//--- Bender.yml
package:
  name: insn_decoder

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/decode_pkg.sv
  - rtl/insn_classifier.sv
  - rtl/operand_extractor.sv
  - rtl/insn_decoder.sv
  - target: simulation
    files:
      - sim/tb_insn_decoder.sv
